//--- rv_isa_pkg.sv
package rv_isa_pkg;

	typedef enum logic [5:0] {
		NOP,
		LUI, AUIPC, JAL, JALR,
		BEQ, BNE, BLT, BGE, BLTU, BGEU,
		LB, LH, LW, LBU, LHU, SB, SH, SW,
		ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		FENCE, ECALL, EBREAK
	} instr_name_e;

	typedef enum logic [2:0] {
		LK_B, LK_H, LK_W, LK_BU, LK_HU
	} load_kind_e;

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_FENCE  = 7'b0001111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_BEQ  = 3'b000; // Branch compares
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_B  = 3'b000; // Load and store access sizes
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	localparam logic [2:0] F3_ADD_SUB = 3'b000; // ALU operations
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	function automatic logic [31:0] imm_i(input logic [31:0] instr);
		return {{20{instr[31]}}, instr[31:20]};
	endfunction

	function automatic logic [31:0] imm_s(input logic [31:0] instr);
		return {{20{instr[31]}}, instr[31:25], instr[11:7]};
	endfunction

	function automatic logic [31:0] imm_b(input logic [31:0] instr);
		return {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	endfunction

	function automatic logic [31:0] imm_u(input logic [31:0] instr);
		return {instr[31:12], 12'h000};
	endfunction

	function automatic logic [31:0] imm_j(input logic [31:0] instr);
		return {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	endfunction

endpackage

//--- core_cfg_pkg.sv
package core_cfg_pkg;

	localparam int XLEN = 32; // Data and address width

	localparam int NUM_REGS = 32;

	localparam int REG_AW = 5; // Register index width

	localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

endpackage

//--- decode_if.sv
`timescale 1ns/1ns

interface decode_if;

	rv_isa_pkg::instr_name_e name;
	logic [core_cfg_pkg::REG_AW-1:0] rd;
	logic [core_cfg_pkg::REG_AW-1:0] rs1;
	logic [core_cfg_pkg::REG_AW-1:0] rs2;
	logic [core_cfg_pkg::XLEN-1:0] imm; // Already extended and scaled for its format
	logic rd_we;
	logic [2:0] funct3;

	modport dec (
		output name, rd, rs1, rs2, imm, rd_we, funct3
	);

	modport exe (
		input name, rd, rs1, rs2, imm, rd_we, funct3
	);

endinterface

//--- result_if.sv
`timescale 1ns/1ns

interface result_if;

	logic [core_cfg_pkg::REG_AW-1:0] rs1_addr;
	logic [core_cfg_pkg::REG_AW-1:0] rs2_addr;
	logic [core_cfg_pkg::XLEN-1:0] rs1_data;
	logic [core_cfg_pkg::XLEN-1:0] rs2_data;
	logic wr_en;
	logic [core_cfg_pkg::REG_AW-1:0] wr_addr;
	logic [core_cfg_pkg::XLEN-1:0] wr_data;
	logic is_load; // Write value comes from the data memory lane
	rv_isa_pkg::load_kind_e load_kind;
	logic [1:0] load_addr_lo;

	modport exe (
		output rs1_addr, rs2_addr, wr_en, wr_addr, wr_data, is_load, load_kind, load_addr_lo,
		input rs1_data, rs2_data
	);

	modport res (
		input rs1_addr, rs2_addr, wr_en, wr_addr, wr_data, is_load, load_kind, load_addr_lo,
		output rs1_data, rs2_data
	);

endinterface

//--- instr_decode.sv
`timescale 1ns/1ns

module instr_decode (
	input logic [core_cfg_pkg::XLEN-1:0] i_instr,
	decode_if.dec o_dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [core_cfg_pkg::REG_AW-1:0] rd;
	rv_isa_pkg::instr_name_e name;

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];
	assign rd = i_instr[11:7];

	always_comb begin
		name = rv_isa_pkg::NOP; // Anything not matched below retires as NOP
		case (opcode)
			rv_isa_pkg::OP_LUI: name = rv_isa_pkg::LUI;
			rv_isa_pkg::OP_AUIPC: name = rv_isa_pkg::AUIPC;
			rv_isa_pkg::OP_JAL: name = rv_isa_pkg::JAL;
			rv_isa_pkg::OP_JALR: begin
				if (funct3 == 3'b000)
					name = rv_isa_pkg::JALR;
			end
			rv_isa_pkg::OP_BRANCH: begin
				case (funct3)
					rv_isa_pkg::F3_BEQ: name = rv_isa_pkg::BEQ;
					rv_isa_pkg::F3_BNE: name = rv_isa_pkg::BNE;
					rv_isa_pkg::F3_BLT: name = rv_isa_pkg::BLT;
					rv_isa_pkg::F3_BGE: name = rv_isa_pkg::BGE;
					rv_isa_pkg::F3_BLTU: name = rv_isa_pkg::BLTU;
					rv_isa_pkg::F3_BGEU: name = rv_isa_pkg::BGEU;
					default: ;
				endcase
			end
			rv_isa_pkg::OP_LOAD: begin
				case (funct3)
					rv_isa_pkg::F3_B: name = rv_isa_pkg::LB;
					rv_isa_pkg::F3_H: name = rv_isa_pkg::LH;
					rv_isa_pkg::F3_W: name = rv_isa_pkg::LW;
					rv_isa_pkg::F3_BU: name = rv_isa_pkg::LBU;
					rv_isa_pkg::F3_HU: name = rv_isa_pkg::LHU;
					default: ;
				endcase
			end
			rv_isa_pkg::OP_STORE: begin
				case (funct3)
					rv_isa_pkg::F3_B: name = rv_isa_pkg::SB;
					rv_isa_pkg::F3_H: name = rv_isa_pkg::SH;
					rv_isa_pkg::F3_W: name = rv_isa_pkg::SW;
					default: ;
				endcase
			end
			rv_isa_pkg::OP_IMM: begin
				case (funct3)
					rv_isa_pkg::F3_ADD_SUB: name = rv_isa_pkg::ADDI;
					rv_isa_pkg::F3_SLT: name = rv_isa_pkg::SLTI;
					rv_isa_pkg::F3_SLTU: name = rv_isa_pkg::SLTIU;
					rv_isa_pkg::F3_XOR: name = rv_isa_pkg::XORI;
					rv_isa_pkg::F3_OR: name = rv_isa_pkg::ORI;
					rv_isa_pkg::F3_AND: name = rv_isa_pkg::ANDI;
					rv_isa_pkg::F3_SLL: begin
						if (funct7 == 7'b0000000)
							name = rv_isa_pkg::SLLI;
					end
					rv_isa_pkg::F3_SR: begin
						if (funct7 == 7'b0000000)
							name = rv_isa_pkg::SRLI;
						else if (funct7 == 7'b0100000)
							name = rv_isa_pkg::SRAI;
					end
					default: ;
				endcase
			end
			rv_isa_pkg::OP_REG: begin
				if (funct7 == 7'b0000000) begin
					case (funct3)
						rv_isa_pkg::F3_ADD_SUB: name = rv_isa_pkg::ADD;
						rv_isa_pkg::F3_SLL: name = rv_isa_pkg::SLL;
						rv_isa_pkg::F3_SLT: name = rv_isa_pkg::SLT;
						rv_isa_pkg::F3_SLTU: name = rv_isa_pkg::SLTU;
						rv_isa_pkg::F3_XOR: name = rv_isa_pkg::XOR;
						rv_isa_pkg::F3_SR: name = rv_isa_pkg::SRL;
						rv_isa_pkg::F3_OR: name = rv_isa_pkg::OR;
						default: name = rv_isa_pkg::AND;
					endcase
				end else if (funct7 == 7'b0100000) begin
					if (funct3 == rv_isa_pkg::F3_ADD_SUB)
						name = rv_isa_pkg::SUB;
					else if (funct3 == rv_isa_pkg::F3_SR)
						name = rv_isa_pkg::SRA;
				end
			end
			rv_isa_pkg::OP_FENCE: begin
				if (funct3 == 3'b000)
					name = rv_isa_pkg::FENCE;
			end
			rv_isa_pkg::OP_SYSTEM: begin
				if (i_instr[31:7] == 25'h0000000)
					name = rv_isa_pkg::ECALL;
				else if (i_instr[31:7] == 25'h0002000) // Only bit 20 set
					name = rv_isa_pkg::EBREAK;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (opcode)
			rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC: o_dec.imm = rv_isa_pkg::imm_u(i_instr);
			rv_isa_pkg::OP_JAL: o_dec.imm = rv_isa_pkg::imm_j(i_instr);
			rv_isa_pkg::OP_BRANCH: o_dec.imm = rv_isa_pkg::imm_b(i_instr);
			rv_isa_pkg::OP_STORE: o_dec.imm = rv_isa_pkg::imm_s(i_instr);
			default: o_dec.imm = rv_isa_pkg::imm_i(i_instr); // Shifts take imm[4:0]
		endcase
	end

	assign o_dec.name = name;
	assign o_dec.rd = rd;
	assign o_dec.rs1 = i_instr[19:15];
	assign o_dec.rs2 = i_instr[24:20];
	assign o_dec.funct3 = funct3;

	// Branches, stores and the NOP class leave rd alone, and x0 is never written
	assign o_dec.rd_we = (rd != '0) && !(name inside {rv_isa_pkg::NOP, rv_isa_pkg::FENCE,
		rv_isa_pkg::ECALL, rv_isa_pkg::EBREAK, rv_isa_pkg::BEQ, rv_isa_pkg::BNE,
		rv_isa_pkg::BLT, rv_isa_pkg::BGE, rv_isa_pkg::BLTU, rv_isa_pkg::BGEU,
		rv_isa_pkg::SB, rv_isa_pkg::SH, rv_isa_pkg::SW});

endmodule

//--- alu_execute.sv
`timescale 1ns/1ns

module alu_execute (
	input logic clk,
	input logic mif,
	output logic [core_cfg_pkg::XLEN-1:0] o_pc,
	output logic [core_cfg_pkg::XLEN-1:0] o_dmem_addr,
	output logic [core_cfg_pkg::XLEN-1:0] o_dmem_wdata,
	output logic [core_cfg_pkg::XLEN/8-1:0] o_dmem_be,
	output logic o_dmem_we,
	decode_if.exe o_dec,
	result_if.exe o_res
);

	logic [core_cfg_pkg::XLEN-1:0] pc_q;
	logic [core_cfg_pkg::XLEN-1:0] pc_plus4;
	logic [core_cfg_pkg::XLEN-1:0] rs1_val;
	logic [core_cfg_pkg::XLEN-1:0] rs2_val;
	logic [core_cfg_pkg::XLEN-1:0] ea; // rs1 + imm, shared by loads, stores and JALR
	logic [core_cfg_pkg::XLEN-1:0] alu_out;
	logic [core_cfg_pkg::XLEN-1:0] next_pc;
	logic take_branch;
	logic is_store;

	assign o_res.rs1_addr = o_dec.rs1;
	assign o_res.rs2_addr = o_dec.rs2;
	assign rs1_val = o_res.rs1_data;
	assign rs2_val = o_res.rs2_data;

	assign pc_plus4 = pc_q + 32'd4;
	assign ea = rs1_val + o_dec.imm;

	always_comb begin
		case (o_dec.name)
			rv_isa_pkg::LUI: alu_out = o_dec.imm;
			rv_isa_pkg::AUIPC: alu_out = pc_q + o_dec.imm;
			rv_isa_pkg::JAL, rv_isa_pkg::JALR: alu_out = pc_plus4; // Link value
			rv_isa_pkg::ADDI: alu_out = ea;
			rv_isa_pkg::SLTI: alu_out = {31'b0, $signed(rs1_val) < $signed(o_dec.imm)};
			rv_isa_pkg::SLTIU: alu_out = {31'b0, rs1_val < o_dec.imm};
			rv_isa_pkg::XORI: alu_out = rs1_val ^ o_dec.imm;
			rv_isa_pkg::ORI: alu_out = rs1_val | o_dec.imm;
			rv_isa_pkg::ANDI: alu_out = rs1_val & o_dec.imm;
			rv_isa_pkg::SLLI: alu_out = rs1_val << o_dec.imm[4:0];
			rv_isa_pkg::SRLI: alu_out = rs1_val >> o_dec.imm[4:0];
			rv_isa_pkg::SRAI: alu_out = $signed(rs1_val) >>> o_dec.imm[4:0];
			rv_isa_pkg::ADD: alu_out = rs1_val + rs2_val;
			rv_isa_pkg::SUB: alu_out = rs1_val - rs2_val;
			rv_isa_pkg::SLL: alu_out = rs1_val << rs2_val[4:0];
			rv_isa_pkg::SLT: alu_out = {31'b0, $signed(rs1_val) < $signed(rs2_val)};
			rv_isa_pkg::SLTU: alu_out = {31'b0, rs1_val < rs2_val};
			rv_isa_pkg::XOR: alu_out = rs1_val ^ rs2_val;
			rv_isa_pkg::SRL: alu_out = rs1_val >> rs2_val[4:0];
			rv_isa_pkg::SRA: alu_out = $signed(rs1_val) >>> rs2_val[4:0];
			rv_isa_pkg::OR: alu_out = rs1_val | rs2_val;
			rv_isa_pkg::AND: alu_out = rs1_val & rs2_val;
			default: alu_out = '0; // Loads take their value in writeback
		endcase
	end

	always_comb begin
		case (o_dec.name)
			rv_isa_pkg::BEQ: take_branch = rs1_val == rs2_val;
			rv_isa_pkg::BNE: take_branch = rs1_val != rs2_val;
			rv_isa_pkg::BLT: take_branch = $signed(rs1_val) < $signed(rs2_val);
			rv_isa_pkg::BGE: take_branch = $signed(rs1_val) >= $signed(rs2_val);
			rv_isa_pkg::BLTU: take_branch = rs1_val < rs2_val;
			rv_isa_pkg::BGEU: take_branch = rs1_val >= rs2_val;
			default: take_branch = 1'b0;
		endcase
	end

	always_comb begin
		next_pc = pc_plus4;
		if (o_dec.name == rv_isa_pkg::JAL || take_branch)
			next_pc = pc_q + o_dec.imm;
		else if (o_dec.name == rv_isa_pkg::JALR)
			next_pc = {ea[core_cfg_pkg::XLEN-1:1], 1'b0};
	end

	always_ff @(posedge clk or negedge mif) begin
		if (!mif)
			pc_q <= core_cfg_pkg::RESET_PC;
		else
			pc_q <= next_pc;
	end

	assign o_pc = pc_q;

	// funct3[1:0] gives the access size, low address bits below it are dropped
	always_comb begin
		case (o_dec.funct3[1:0])
			2'b00: o_dmem_addr = ea;
			2'b01: o_dmem_addr = {ea[core_cfg_pkg::XLEN-1:1], 1'b0};
			default: o_dmem_addr = {ea[core_cfg_pkg::XLEN-1:2], 2'b00};
		endcase
	end

	always_comb begin
		o_dmem_wdata = rs2_val;
		o_dmem_be = '0;
		case (o_dec.name)
			rv_isa_pkg::SB: begin
				o_dmem_wdata = {4{rs2_val[7:0]}}; // Byte copied to every lane
				o_dmem_be = 4'b0001 << o_dmem_addr[1:0];
			end
			rv_isa_pkg::SH: begin
				o_dmem_wdata = {2{rs2_val[15:0]}};
				o_dmem_be = o_dmem_addr[1] ? 4'b1100 : 4'b0011;
			end
			rv_isa_pkg::SW: o_dmem_be = 4'b1111;
			default: ;
		endcase
	end

	assign is_store = o_dec.name inside {rv_isa_pkg::SB, rv_isa_pkg::SH, rv_isa_pkg::SW};
	assign o_dmem_we = is_store && mif;

	always_comb begin
		o_res.is_load = 1'b1;
		case (o_dec.name)
			rv_isa_pkg::LB: o_res.load_kind = rv_isa_pkg::LK_B;
			rv_isa_pkg::LH: o_res.load_kind = rv_isa_pkg::LK_H;
			rv_isa_pkg::LW: o_res.load_kind = rv_isa_pkg::LK_W;
			rv_isa_pkg::LBU: o_res.load_kind = rv_isa_pkg::LK_BU;
			rv_isa_pkg::LHU: o_res.load_kind = rv_isa_pkg::LK_HU;
			default: begin
				o_res.is_load = 1'b0;
				o_res.load_kind = rv_isa_pkg::LK_W;
			end
		endcase
	end

	assign o_res.load_addr_lo = o_dmem_addr[1:0];
	assign o_res.wr_en = o_dec.rd_we && mif; // No architectural write is shown during reset
	assign o_res.wr_addr = o_dec.rd;
	assign o_res.wr_data = alu_out;

endmodule

//--- result_writeback.sv
`timescale 1ns/1ns

module result_writeback (
	input logic clk,
	input logic mif,
	input logic [core_cfg_pkg::XLEN-1:0] i_dmem_rdata,
	input logic [core_cfg_pkg::XLEN-1:0] i_pc,
	result_if.res o_res,
	output logic o_retire_valid,
	output logic [core_cfg_pkg::XLEN-1:0] o_retire_pc,
	output logic o_retire_we,
	output logic [core_cfg_pkg::REG_AW-1:0] o_retire_rd,
	output logic [core_cfg_pkg::XLEN-1:0] o_retire_data
);

	logic [core_cfg_pkg::XLEN-1:0] regs [core_cfg_pkg::NUM_REGS];
	logic [core_cfg_pkg::XLEN-1:0] load_val;
	logic [core_cfg_pkg::XLEN-1:0] wr_val;
	logic [7:0] lane_b;
	logic [15:0] lane_h;

	assign o_res.rs1_data = (o_res.rs1_addr == '0) ? '0 : regs[o_res.rs1_addr];
	assign o_res.rs2_data = (o_res.rs2_addr == '0) ? '0 : regs[o_res.rs2_addr];

	always_comb begin
		case (o_res.load_addr_lo)
			2'd0: lane_b = i_dmem_rdata[7:0];
			2'd1: lane_b = i_dmem_rdata[15:8];
			2'd2: lane_b = i_dmem_rdata[23:16];
			default: lane_b = i_dmem_rdata[31:24];
		endcase
		lane_h = o_res.load_addr_lo[1] ? i_dmem_rdata[31:16] : i_dmem_rdata[15:0];
	end

	always_comb begin
		case (o_res.load_kind)
			rv_isa_pkg::LK_B: load_val = {{24{lane_b[7]}}, lane_b};
			rv_isa_pkg::LK_BU: load_val = {24'h000000, lane_b};
			rv_isa_pkg::LK_H: load_val = {{16{lane_h[15]}}, lane_h};
			rv_isa_pkg::LK_HU: load_val = {16'h0000, lane_h};
			default: load_val = i_dmem_rdata;
		endcase
	end

	assign wr_val = o_res.is_load ? load_val : o_res.wr_data;

	always_ff @(posedge clk or negedge mif) begin
		if (!mif) begin
			for (int i = 0; i < core_cfg_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (o_res.wr_en) begin
			regs[o_res.wr_addr] <= wr_val; // Decode never requests rd = x0
		end
	end

	// The trace shows the instruction that retires on the coming edge
	assign o_retire_valid = mif;
	assign o_retire_pc = i_pc;
	assign o_retire_we = o_res.wr_en;
	assign o_retire_rd = o_res.wr_addr;
	assign o_retire_data = wr_val;

endmodule

//--- rv_core.sv
`timescale 1ns/1ns

module rv_core (
	input logic clk,
	input logic mif,
	output logic [core_cfg_pkg::XLEN-1:0] o_imem_addr,
	input logic [core_cfg_pkg::XLEN-1:0] i_imem_data,
	output logic [core_cfg_pkg::XLEN-1:0] o_dmem_addr,
	output logic [core_cfg_pkg::XLEN-1:0] o_dmem_wdata,
	output logic [core_cfg_pkg::XLEN/8-1:0] o_dmem_be,
	output logic o_dmem_we,
	input logic [core_cfg_pkg::XLEN-1:0] i_dmem_rdata,
	output logic o_retire_valid,
	output logic [core_cfg_pkg::XLEN-1:0] o_retire_pc,
	output logic o_retire_we,
	output logic [core_cfg_pkg::REG_AW-1:0] o_retire_rd,
	output logic [core_cfg_pkg::XLEN-1:0] o_retire_data
);

	decode_if dec_bus ();
	result_if res_bus ();

	instr_decode u_decode (
		.i_instr (i_imem_data),
		.o_dec   (dec_bus.dec)
	);

	alu_execute u_execute (
		.clk          (clk),
		.mif          (mif),
		.o_pc         (o_imem_addr), // The PC is the fetch address
		.o_dmem_addr  (o_dmem_addr),
		.o_dmem_wdata (o_dmem_wdata),
		.o_dmem_be    (o_dmem_be),
		.o_dmem_we    (o_dmem_we),
		.o_dec        (dec_bus.exe),
		.o_res        (res_bus.exe)
	);

	result_writeback u_writeback (
		.clk            (clk),
		.mif            (mif),
		.i_dmem_rdata   (i_dmem_rdata),
		.i_pc           (o_imem_addr),
		.o_res          (res_bus.res),
		.o_retire_valid (o_retire_valid),
		.o_retire_pc    (o_retire_pc),
		.o_retire_we    (o_retire_we),
		.o_retire_rd    (o_retire_rd),
		.o_retire_data  (o_retire_data)
	);

endmodule

//--- rv_core_properties.sv
`timescale 1ns/1ns

module rv_core_properties (
	input logic clk,
	input logic mif,
	input logic [core_cfg_pkg::XLEN-1:0] i_imem_addr,
	input logic i_dmem_we,
	input logic i_retire_valid,
	input logic i_retire_we,
	input logic [core_cfg_pkg::REG_AW-1:0] i_retire_rd
);

	reset_quiet: assert property (@(posedge clk) !mif |-> !i_dmem_we && !i_retire_we)
		else $error("Write strobe active while the core is in reset");

	fetch_aligned: assert property (@(posedge clk) disable iff (!mif) i_imem_addr[1:0] == 2'b00)
		else $error("Fetch address is not word aligned");

	no_x0_write: assert property (@(posedge clk) i_retire_we |-> i_retire_rd != '0)
		else $error("Retire port reports a write to x0");

	// A single-cycle core retires on every clock once reset is released
	retire_each_cycle: assert property (@(posedge clk) disable iff (!mif) i_retire_valid)
		else $error("No retirement in a cycle after reset");

endmodule

bind rv_core rv_core_properties u_props (
	.clk            (clk),
	.mif            (mif),
	.i_imem_addr    (o_imem_addr),
	.i_dmem_we      (o_dmem_we),
	.i_retire_valid (o_retire_valid),
	.i_retire_we    (o_retire_we),
	.i_retire_rd    (o_retire_rd)
);

//--- tb_iss_model.svh
`ifndef TB_ISS_MODEL_SVH
`define TB_ISS_MODEL_SVH

logic [31:0] m_regs [32]; // Shadow architectural state
logic [31:0] m_mem [256];
logic [31:0] m_pc;

task automatic model_reset();
	for (int i = 0; i < 32; i++) begin
		m_regs[i] = '0;
	end
	for (int i = 0; i < 256; i++) begin
		m_mem[i] = fill_word(DMEM_BASE + 32'(4 * i));
	end
	m_pc = core_cfg_pkg::RESET_PC;
endtask

// Executes the instruction at the shadow PC and reports what it retires
task automatic iss_step(output logic [31:0] pc_o, output logic we_o, output logic [4:0] rd_o,
	output logic [31:0] data_o);
	logic [31:0] ins;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm_iv;
	logic [31:0] imm_sv;
	logic [31:0] imm_bv;
	logic [31:0] imm_jv;
	logic [31:0] addr;
	logic [31:0] word;
	logic [31:0] res;
	logic [31:0] npc;
	logic [7:0] byte_v;
	logic [15:0] half_v;
	logic [2:0] f3;
	logic [4:0] rd;
	logic alt;
	logic writes;
	logic taken;
	ins = prog[m_pc[9:2]];
	f3 = ins[14:12];
	rd = ins[11:7];
	alt = ins[30]; // Selects SUB and the arithmetic shifts
	a = m_regs[ins[19:15]];
	b = m_regs[ins[24:20]];
	imm_iv = {{20{ins[31]}}, ins[31:20]};
	imm_sv = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	imm_bv = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
	imm_jv = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
	writes = 1'b0;
	taken = 1'b0;
	res = '0;
	npc = m_pc + 32'd4;
	case (ins[6:0])
		rv_isa_pkg::OP_LUI: begin
			writes = 1'b1;
			res = {ins[31:12], 12'h000};
		end
		rv_isa_pkg::OP_AUIPC: begin
			writes = 1'b1;
			res = m_pc + {ins[31:12], 12'h000};
		end
		rv_isa_pkg::OP_JAL: begin
			writes = 1'b1;
			res = m_pc + 32'd4;
			npc = m_pc + imm_jv;
		end
		rv_isa_pkg::OP_JALR: begin
			writes = 1'b1;
			res = m_pc + 32'd4;
			npc = (a + imm_iv) & ~32'd1;
		end
		rv_isa_pkg::OP_BRANCH: begin
			case (f3)
				3'b000: taken = (a == b);
				3'b001: taken = (a != b);
				3'b100: taken = ($signed(a) < $signed(b));
				3'b101: taken = ($signed(a) >= $signed(b));
				3'b110: taken = (a < b);
				default: taken = (a >= b);
			endcase
			if (taken)
				npc = m_pc + imm_bv;
		end
		rv_isa_pkg::OP_LOAD: begin
			writes = 1'b1;
			addr = a + imm_iv;
			word = m_mem[addr[9:2]]; // Low address bits only pick the lane
			byte_v = word[{addr[1:0], 3'b000} +: 8];
			half_v = word[{addr[1], 4'b0000} +: 16];
			case (f3)
				3'b000: res = {{24{byte_v[7]}}, byte_v};
				3'b001: res = {{16{half_v[15]}}, half_v};
				3'b100: res = {24'h000000, byte_v};
				3'b101: res = {16'h0000, half_v};
				default: res = word;
			endcase
		end
		rv_isa_pkg::OP_STORE: begin
			addr = a + imm_sv;
			word = m_mem[addr[9:2]];
			case (f3)
				3'b000: word[{addr[1:0], 3'b000} +: 8] = b[7:0];
				3'b001: word[{addr[1], 4'b0000} +: 16] = b[15:0];
				default: word = b;
			endcase
			m_mem[addr[9:2]] = word;
		end
		rv_isa_pkg::OP_IMM: begin
			writes = 1'b1;
			case (f3)
				3'b000: res = a + imm_iv;
				3'b001: res = a << imm_iv[4:0];
				3'b010: res = {31'b0, $signed(a) < $signed(imm_iv)};
				3'b011: res = {31'b0, a < imm_iv};
				3'b100: res = a ^ imm_iv;
				3'b101: begin
					if (alt)
						res = $signed(a) >>> imm_iv[4:0];
					else
						res = a >> imm_iv[4:0];
				end
				3'b110: res = a | imm_iv;
				default: res = a & imm_iv;
			endcase
		end
		rv_isa_pkg::OP_REG: begin
			writes = 1'b1;
			case (f3)
				3'b000: res = alt ? a - b : a + b;
				3'b001: res = a << b[4:0];
				3'b010: res = {31'b0, $signed(a) < $signed(b)};
				3'b011: res = {31'b0, a < b};
				3'b100: res = a ^ b;
				3'b101: begin
					if (alt)
						res = $signed(a) >>> b[4:0];
					else
						res = a >> b[4:0];
				end
				3'b110: res = a | b;
				default: res = a & b;
			endcase
		end
		default: ; // FENCE, ECALL, EBREAK and unknown words change nothing
	endcase
	if (rd == 5'd0)
		writes = 1'b0;
	if (writes)
		m_regs[rd] = res;
	pc_o = m_pc;
	we_o = writes;
	rd_o = rd;
	data_o = res;
	m_pc = npc;
endtask

`endif

//--- tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;

	localparam int PROG_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int SETUP_LEN = 3;
	localparam int RAND_LEN = 200;
	localparam int LAST_IDX = SETUP_LEN + RAND_LEN; // Index of the final jump to itself
	localparam int RETIRE_TIMEOUT = 20;
	localparam logic [31:0] DMEM_BASE = 32'h0001_0000;
	localparam logic [31:0] END_PC = core_cfg_pkg::RESET_PC + 32'(4 * LAST_IDX);

	logic clk;
	logic mif;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic [3:0] dmem_be;
	logic dmem_we;
	logic [31:0] dmem_rdata;
	logic retire_valid;
	logic [31:0] retire_pc;
	logic retire_we;
	logic [4:0] retire_rd;
	logic [31:0] retire_data;

	logic [31:0] prog [PROG_WORDS];
	logic [31:0] dmem [DMEM_WORDS];
	integer seed;
	int value_errors;
	int other_errors;
	int retired;
	logic done;
	logic seen;
	logic [31:0] exp_pc;
	logic exp_we;
	logic [4:0] exp_rd;
	logic [31:0] exp_data;

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
	endfunction

	`include "tb_iss_model.svh"

	rv_core i_dut (
		.clk            (clk),
		.mif            (mif),
		.o_imem_addr    (imem_addr),
		.i_imem_data    (imem_data),
		.o_dmem_addr    (dmem_addr),
		.o_dmem_wdata   (dmem_wdata),
		.o_dmem_be      (dmem_be),
		.o_dmem_we      (dmem_we),
		.i_dmem_rdata   (dmem_rdata),
		.o_retire_valid (retire_valid),
		.o_retire_pc    (retire_pc),
		.o_retire_we    (retire_we),
		.o_retire_rd    (retire_rd),
		.o_retire_data  (retire_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	assign imem_data = prog[imem_addr[9:2]]; // Both memories answer in the same cycle
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
		input logic [3:0] be);
		logic [31:0] w;
		w = old_w;
		for (int i = 0; i < 4; i++) begin
			if (be[i])
				w[8*i +: 8] = new_w[8*i +: 8];
		end
		return w;
	endfunction

	always @(posedge clk) begin
		if (mif && dmem_we)
			dmem[dmem_addr[9:2]] <= merge_bytes(dmem[dmem_addr[9:2]], dmem_wdata, dmem_be);
	end

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::OP_STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OP_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OP_JAL};
	endfunction

	// x10 holds the data base and x11 the code base, random code never writes them
	task automatic build_program();
		int hop;
		logic [4:0] rd;
		logic [2:0] f3;
		logic [11:0] imm12;
		logic [11:0] shamt;
		prog[0] = u_type(20'h00010, 5'd10, rv_isa_pkg::OP_LUI);
		prog[1] = i_type(12'h200, 5'd10, 3'b000, 5'd10, rv_isa_pkg::OP_IMM);
		prog[2] = u_type(20'h80000, 5'd11, rv_isa_pkg::OP_LUI);
		for (int k = SETUP_LEN; k < PROG_WORDS; k++) begin
			hop = 1 + int'(rand_below(8));
			if (k + hop > LAST_IDX)
				hop = LAST_IDX - k; // Forward only, never past the final jump
			rd = 5'(rand_below(10));
			f3 = 3'(rand_below(8));
			imm12 = 12'(int'(rand_below(1024)) - 512); // Keeps accesses inside the data memory
			shamt = {7'b0000000, 5'(rand_below(32))};
			if (k >= LAST_IDX) begin
				prog[k] = j_type(21'd0, 5'd0);
			end else begin
				case (rand_below(20))
					0: prog[k] = u_type(20'(rand_below(32'hfffff)), rd, rv_isa_pkg::OP_LUI);
					1: prog[k] = u_type(20'(rand_below(32'hfffff)), rd, rv_isa_pkg::OP_AUIPC);
					2, 3, 4, 5: begin
						if (f3 == 3'b001)
							imm12 = shamt;
						else if (f3 == 3'b101)
							imm12 = shamt | (rand_below(2) != 0 ? 12'h400 : 12'h000);
						else
							imm12 = 12'($random(seed));
						prog[k] = i_type(imm12, 5'(rand_below(10)), f3, rd, rv_isa_pkg::OP_IMM);
					end
					6, 7, 8, 9: prog[k] = r_type((f3 == 3'b000 || f3 == 3'b101) &&
						rand_below(2) != 0 ? 7'b0100000 : 7'b0000000, 5'(rand_below(10)),
						5'(rand_below(10)), f3, rd);
					10, 11: begin
						case (rand_below(5))
							0: f3 = 3'b000;
							1: f3 = 3'b001;
							2: f3 = 3'b010;
							3: f3 = 3'b100;
							default: f3 = 3'b101;
						endcase
						prog[k] = i_type(imm12, 5'd10, f3, rd, rv_isa_pkg::OP_LOAD);
					end
					12, 13: prog[k] = s_type(imm12, 5'(rand_below(10)), 5'd10,
						3'(rand_below(3)));
					14, 15, 16: begin
						case (rand_below(6))
							0: f3 = 3'b000;
							1: f3 = 3'b001;
							2: f3 = 3'b100;
							3: f3 = 3'b101;
							4: f3 = 3'b110;
							default: f3 = 3'b111;
						endcase
						prog[k] = b_type(13'(hop * 4), 5'(rand_below(10)), 5'(rand_below(10)), f3);
					end
					17: prog[k] = j_type(21'(hop * 4), rd);
					18: prog[k] = i_type(12'((k + hop) * 4 + int'(rand_below(2))), 5'd11, 3'b000,
						rd, rv_isa_pkg::OP_JALR); // Bit 0 of the sum is cleared by JALR
					default: begin
						case (rand_below(4))
							0: prog[k] = i_type(12'h000, 5'd0, 3'b000, 5'd0, rv_isa_pkg::OP_FENCE);
							1: prog[k] = 32'h0000_0073;
							2: prog[k] = 32'h0010_0073;
							default: prog[k] = {25'($random(seed)), 7'b1111111};
						endcase
					end
				endcase
			end
		end
	endtask

	task automatic check_value(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s: expected %h, actual %h", test, expected, actual);
			value_errors++;
		end
	endtask

	task automatic wait_retire(output logic ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < RETIRE_TIMEOUT) begin
			@(negedge clk);
			ok = retire_valid;
			cycles++;
		end
		if (!ok) begin
			$display("ERROR: the core retired nothing for %0d cycles", RETIRE_TIMEOUT);
			other_errors++;
		end
	endtask

	initial begin
		mif = 1'b0;
		seed = 32'hb5a002f3;
		value_errors = 0;
		other_errors = 0;
		retired = 0;
		done = 1'b0;
		seen = 1'b1;
		build_program();
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = fill_word(DMEM_BASE + 32'(4 * i));
		end
		model_reset();
		repeat (2) @(posedge clk);
		#1 mif = 1'b1;
		while (!done && seen && retired <= LAST_IDX + 8) begin
			wait_retire(seen);
			if (seen) begin
				iss_step(exp_pc, exp_we, exp_rd, exp_data);
				check_value("retire_pc", exp_pc, retire_pc);
				check_value($sformatf("retire_we @%h", exp_pc), {31'b0, exp_we}, {31'b0, retire_we});
				if (exp_we) begin
					check_value($sformatf("retire_rd @%h", exp_pc), {27'b0, exp_rd}, {27'b0, retire_rd});
					check_value($sformatf("retire_data @%h", exp_pc), exp_data, retire_data);
				end
				done = (exp_pc == END_PC);
				retired++;
			end
		end
		if (!done) begin
			$display("ERROR: the program never reached its final jump");
			other_errors++;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			check_value($sformatf("dmem word %0d", i), m_mem[i], dmem[i]);
		end
		$display("Errors: %0d value mismatches, %0d other failures after %0d retirements",
			value_errors, other_errors, retired);
		if (value_errors + other_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+.
rv_isa_pkg.sv
core_cfg_pkg.sv
decode_if.sv
result_if.sv
instr_decode.sv
alu_execute.sv
result_writeback.sv
rv_core.sv
rv_core_properties.sv
tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the rv_core testbench with Verilator and runs it into sim.log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_rv_core -f tb.f
./obj_dir/Vtb_rv_core | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
grep -q "STATUS: PASS" sim.log
